// File: design/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// --------------------
// Logical word space
// --------------------
`define MEM_WIDTH       32    // Bits per logical word
`define MEM_NUMADDR     1024  // Logical words
`define MEM_BITADDR     10

// --------------------
// Physical SRAM rows
// --------------------
`define MEM_NUMWRDS     4     // Word slots per row
`define MEM_BITWRDS     2
`define MEM_NUMSROW     256   // Rows
`define MEM_BITSROW     8

// Read to data cycles inside the SRAM
`define MEM_SRAM_DELAY  2

// Slot followed by row
`define MEM_BITPADR     10

`endif

// File: design/mem_logic_pkg.sv
`default_nettype none

`include "mem_params.svh"

package mem_logic_pkg;

  // --------------------
  // User-facing words
  // --------------------

  // Data word, also used as the per-bit write mask
  typedef logic [`MEM_WIDTH-1:0] word_t;

  typedef logic [`MEM_BITADDR-1:0] laddr_t;  // Logical address
  typedef logic [`MEM_BITPADR-1:0] padr_t;   // Slot then row

  // Where the bits of a read in flight come from
  typedef enum logic {
    RD_SRC_MEM = 1'b0,  // Plain SRAM data
    RD_SRC_FWD = 1'b1   // Same-cycle write merged in
  } rd_src_e;

endpackage

`default_nettype wire

// File: design/mem_phys_pkg.sv
`default_nettype none

`include "mem_params.svh"

package mem_phys_pkg;

  // --------------------
  // SRAM row side
  // --------------------

  // One full row of data or write mask, slot 0 in the low bits
  typedef logic [`MEM_NUMWRDS*`MEM_WIDTH-1:0] row_t;

  typedef logic [`MEM_BITSROW-1:0] radr_t;  // Row address
  typedef logic [`MEM_BITWRDS-1:0] slot_t;  // Word slot in a row

endpackage

`default_nettype wire

// File: design/addr_split.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module addr_split
  import mem_logic_pkg::*;
  import mem_phys_pkg::*;
#(
  parameter int NUMWRDS = `MEM_NUMWRDS
) (
  input  wire laddr_t vaddr,
  output slot_t       slot,
  output radr_t       row
);

  laddr_t row_full;  // Quotient before narrowing to a row address

  generate
    if ((NUMWRDS & (NUMWRDS - 1)) == 0) begin : g_pow2
      localparam int SHIFT = $clog2(NUMWRDS);

      assign row_full = vaddr >> SHIFT;
      assign slot     = slot_t'(vaddr & laddr_t'(NUMWRDS - 1));  // Low bits
    end else begin : g_npow2
      // Constant divisor
      assign row_full = vaddr / laddr_t'(NUMWRDS);
      assign slot     = slot_t'(vaddr % laddr_t'(NUMWRDS));
    end
  endgenerate

  assign row = radr_t'(row_full);

  // Odd slot counts can leave rows past the end of the SRAM
  always_comb begin
    if (!$isunknown(vaddr)) begin
      row_in_range: assert (int'(row_full) < `MEM_NUMSROW)
        else $error("addr_split: row %0d beyond SRAM for address %0d", row_full, vaddr);
    end
  end

endmodule

`default_nettype wire

// File: design/align_bw_1r1w.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module align_bw_1r1w
  import mem_logic_pkg::*;
  import mem_phys_pkg::*;
(
  input  wire         clk,
  input  wire         reset,

  input  wire         write,
  input  wire laddr_t wr_adr,
  input  wire word_t  bw,
  input  wire word_t  din,
  input  wire         read,
  input  wire laddr_t rd_adr,

  output logic        mem_write,
  output radr_t       mem_wr_adr,
  output row_t        mem_bw,
  output row_t        mem_din,
  output logic        mem_read,
  output radr_t       mem_rd_adr,
  input  wire row_t   mem_rd_dout,

  output logic        rd_vld,
  output word_t       rd_dout,
  output logic        rd_fwrd,
  output padr_t       rd_padr
);

  localparam int DLY = `MEM_SRAM_DELAY;

  logic    write_q;
  laddr_t  wr_adr_q;
  word_t   bw_q;
  word_t   din_q;
  logic    read_q;
  laddr_t  rd_adr_q;

  slot_t   wr_slot;
  radr_t   wr_row;
  slot_t   rd_slot;
  radr_t   rd_row;
  logic    fwd_hit;

  logic    vld_p  [DLY];
  rd_src_e src_p  [DLY];
  slot_t   slot_p [DLY];
  radr_t   row_p  [DLY];
  word_t   mask_p [DLY];
  word_t   data_p [DLY];

  word_t   mem_word;
  word_t   merged;

  // --------------------
  // Input register
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      write_q <= 1'b0;
      read_q  <= 1'b0;
    end else begin
      write_q <= write;
      read_q  <= read;
    end
  end

  always_ff @(posedge clk) begin
    wr_adr_q <= wr_adr;
    bw_q     <= bw;
    din_q    <= din;
    rd_adr_q <= rd_adr;
  end

  addr_split wr_split_i (
    .vaddr (wr_adr_q),
    .slot  (wr_slot),
    .row   (wr_row)
  );

  addr_split rd_split_i (
    .vaddr (rd_adr_q),
    .slot  (rd_slot),
    .row   (rd_row)
  );

  // --------------------
  // SRAM commands
  // --------------------
  assign mem_write  = write_q;
  assign mem_wr_adr = wr_row;
  assign mem_bw     = row_t'(bw_q) << (wr_slot * `MEM_WIDTH);  // Other slots masked off
  assign mem_din    = row_t'(din_q) << (wr_slot * `MEM_WIDTH);
  assign mem_read   = read_q;
  assign mem_rd_adr = rd_row;

  // SRAM returns old data, so same-address writes are merged here
  assign fwd_hit = read_q && write_q && (rd_adr_q == wr_adr_q);

  // --------------------
  // Read pipeline
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DLY; i++) begin
        vld_p[i] <= 1'b0;
        src_p[i] <= RD_SRC_MEM;
      end
    end else begin
      vld_p[0] <= read_q;
      src_p[0] <= fwd_hit ? RD_SRC_FWD : RD_SRC_MEM;
      for (int i = 1; i < DLY; i++) begin
        vld_p[i] <= vld_p[i-1];
        src_p[i] <= src_p[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    slot_p[0] <= rd_slot;
    row_p[0]  <= rd_row;
    mask_p[0] <= fwd_hit ? bw_q : '0;  // Bits taken from the write
    data_p[0] <= din_q;
    for (int i = 1; i < DLY; i++) begin
      slot_p[i] <= slot_p[i-1];
      row_p[i]  <= row_p[i-1];
      mask_p[i] <= mask_p[i-1];
      data_p[i] <= data_p[i-1];
    end
  end

  assign mem_word = mem_rd_dout[slot_p[DLY-1]*`MEM_WIDTH +: `MEM_WIDTH];
  assign merged   = (mask_p[DLY-1] & data_p[DLY-1]) | (~mask_p[DLY-1] & mem_word);

  // --------------------
  // Output register
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld  <= 1'b0;
      rd_fwrd <= 1'b0;
    end else begin
      rd_vld  <= vld_p[DLY-1];
      rd_fwrd <= vld_p[DLY-1] && (src_p[DLY-1] == RD_SRC_FWD);
    end
  end

  always_ff @(posedge clk) begin
    rd_dout <= merged;
    rd_padr <= {slot_p[DLY-1], row_p[DLY-1]};
  end

  // Input reg, SRAM delay, output reg
  rd_vld_after_read: assert property (@(posedge clk) disable iff (reset)
    read |-> ##(DLY + 2) rd_vld)
    else $error("align: no rd_vld %0d cycles after read", DLY + 2);

  rd_vld_has_read: assert property (@(posedge clk) disable iff (reset)
    rd_vld |-> $past(read, DLY + 2))
    else $error("align: rd_vld without a matching read");

  // Mask must stay inside the slot of the address written one cycle back
  mem_bw_in_slot: assert property (@(posedge clk) disable iff (reset)
    mem_write |-> (mem_bw & ~(row_t'({`MEM_WIDTH{1'b1}})
                  << (($past(wr_adr) % `MEM_NUMWRDS) * `MEM_WIDTH))) == '0)
    else $error("align: mem_bw set outside the write slot");

endmodule

`default_nettype wire

// File: design/sram_1r1w_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module sram_1r1w_model
  import mem_phys_pkg::*;
(
  input  wire        clk,
  input  wire        reset,

  input  wire        mem_write,
  input  wire radr_t mem_wr_adr,
  input  wire row_t  mem_bw,
  input  wire row_t  mem_din,

  input  wire        mem_read,
  input  wire radr_t mem_rd_adr,
  output row_t       mem_rd_dout
);

  localparam int DLY = `MEM_SRAM_DELAY;

  row_t mem [`MEM_NUMSROW];

  row_t dly_dat [DLY];
  logic dly_vld [DLY];

  // --------------------
  // Write port
  // --------------------
  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem[mem_wr_adr] <= (mem[mem_wr_adr] & ~mem_bw) | (mem_din & mem_bw);  // Per-bit
    end
  end

  // --------------------
  // Read port
  // --------------------
  // Array sampled before this edge's write lands, so same-row reads see old data
  always_ff @(posedge clk) begin
    if (mem_read) begin
      dly_dat[0] <= mem[mem_rd_adr];
    end
    for (int i = 1; i < DLY; i++) begin
      dly_dat[i] <= dly_dat[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DLY; i++) begin
        dly_vld[i] <= 1'b0;
      end
    end else begin
      dly_vld[0] <= mem_read;
      for (int i = 1; i < DLY; i++) begin
        dly_vld[i] <= dly_vld[i-1];
      end
    end
  end

  assign mem_rd_dout = dly_vld[DLY-1] ? dly_dat[DLY-1] : '0;  // Idle bus reads zero

  wr_row_in_range: assert property (@(posedge clk) disable iff (reset)
    mem_write |-> int'(mem_wr_adr) < `MEM_NUMSROW)
    else $error("sram: write row %0d out of range", mem_wr_adr);

  rd_row_in_range: assert property (@(posedge clk) disable iff (reset)
    mem_read |-> int'(mem_rd_adr) < `MEM_NUMSROW)
    else $error("sram: read row %0d out of range", mem_rd_adr);

endmodule

`default_nettype wire

// File: design/mem_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module mem_subsys_top
  import mem_logic_pkg::*;
  import mem_phys_pkg::*;
(
  input  wire         clk,
  input  wire         reset,

  input  wire         write,
  input  wire laddr_t wr_adr,
  input  wire word_t  bw,
  input  wire word_t  din,

  input  wire         read,
  input  wire laddr_t rd_adr,

  output wire         rd_vld,
  output wire word_t  rd_dout,
  output wire         rd_fwrd,
  output wire padr_t  rd_padr
);

  // --------------------
  // Aligner to SRAM
  // --------------------
  wire        mem_write;
  wire radr_t mem_wr_adr;
  wire row_t  mem_bw;
  wire row_t  mem_din;
  wire        mem_read;
  wire radr_t mem_rd_adr;
  wire row_t  mem_rd_dout;

  align_bw_1r1w align_i (
    .clk         (clk),
    .reset       (reset),
    .write       (write),
    .wr_adr      (wr_adr),
    .bw          (bw),
    .din         (din),
    .read        (read),
    .rd_adr      (rd_adr),
    .mem_write   (mem_write),
    .mem_wr_adr  (mem_wr_adr),
    .mem_bw      (mem_bw),
    .mem_din     (mem_din),
    .mem_read    (mem_read),
    .mem_rd_adr  (mem_rd_adr),
    .mem_rd_dout (mem_rd_dout),
    .rd_vld      (rd_vld),
    .rd_dout     (rd_dout),
    .rd_fwrd     (rd_fwrd),
    .rd_padr     (rd_padr)
  );

  sram_1r1w_model sram_i (
    .clk         (clk),
    .reset       (reset),
    .mem_write   (mem_write),
    .mem_wr_adr  (mem_wr_adr),
    .mem_bw      (mem_bw),
    .mem_din     (mem_din),
    .mem_read    (mem_read),
    .mem_rd_adr  (mem_rd_adr),
    .mem_rd_dout (mem_rd_dout)
  );

endmodule

`default_nettype wire

// File: dv/mem_subsys_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module mem_subsys_tb
  import mem_logic_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int RD_LAT     = 4;  // Input reg, SRAM delay, output reg

  localparam int N_INIT  = `MEM_NUMADDR;
  localparam int N_FULL  = 64;
  localparam int N_PART  = 64;
  localparam int N_ROWS  = 16;
  localparam int N_SAME  = 64;
  localparam int N_RAND  = 256;
  localparam int TOTAL_OPS = N_INIT + 2 * N_FULL + 2 * N_PART + N_ROWS * (`MEM_NUMWRDS + 1)
                           + 2 * N_SAME + N_RAND;
  localparam int WATCHDOG_NS = (TOTAL_OPS + 100) * CLK_PERIOD;

  typedef struct packed {
    word_t data;
    logic  fwrd;
    padr_t padr;
  } exp_t;

  logic   clk;
  logic   reset;
  logic   write;
  laddr_t wr_adr;
  word_t  bw;
  word_t  din;
  logic   read;
  laddr_t rd_adr;
  wire    rd_vld;
  word_t  rd_dout;
  wire    rd_fwrd;
  padr_t  rd_padr;

  word_t  shadow [`MEM_NUMADDR];
  exp_t   exp_q [$];
  exp_t   exp_cur;
  laddr_t addr_list [N_FULL];

  mem_subsys_top mem_subsys_top_i (
    .clk     (clk),
    .reset   (reset),
    .write   (write),
    .wr_adr  (wr_adr),
    .bw      (bw),
    .din     (din),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_fwrd (rd_fwrd),
    .rd_padr (rd_padr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // Reference helpers
  // --------------------
  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1, "Simulation stopped at first error");
  endtask

  function automatic word_t merge_masked(input word_t old_w, input word_t new_w, input word_t m);
    return (new_w & m) | (old_w & ~m);
  endfunction

  // Slot in the upper bits, row below
  function automatic padr_t expected_padr(input laddr_t addr);
    int slot;
    int row;
    slot = int'(addr) % `MEM_NUMWRDS;
    row  = int'(addr) / `MEM_NUMWRDS;
    return padr_t'((slot << `MEM_BITSROW) | row);
  endfunction

  function automatic laddr_t rand_addr();
    return laddr_t'($urandom_range(0, `MEM_NUMADDR - 1));
  endfunction

  // Drives one cycle from a falling edge, books the expected read result
  task automatic run_cycle(input logic do_wr, input laddr_t wa, input word_t wm,
                           input word_t wd, input logic do_rd, input laddr_t ra);
    exp_t e;
    write  = do_wr;
    wr_adr = wa;
    bw     = wm;
    din    = wd;
    read   = do_rd;
    rd_adr = ra;
    if (do_rd) begin
      if (do_wr && wa == ra) begin
        e.data = merge_masked(shadow[ra], wd, wm);  // Forwarded merge
        e.fwrd = 1'b1;
      end else begin
        e.data = shadow[ra];
        e.fwrd = 1'b0;
      end
      e.padr = expected_padr(ra);
      exp_q.push_back(e);
    end
    if (do_wr) begin
      shadow[wa] = merge_masked(shadow[wa], wd, wm);
    end
    @(negedge clk);
  endtask

  task automatic idle_cycle();
    run_cycle(1'b0, '0, '0, '0, 1'b0, '0);
  endtask

  // --------------------
  // Result checks
  // --------------------
  always @(negedge clk) begin
    if (rd_vld === 1'b1) begin
      if (exp_q.size() == 0) begin
        stop_on_error("rd_vld went high with no read outstanding");
      end else begin
        exp_cur = exp_q.pop_front();
      end
    end
  end

  vld_low_in_reset: assert property (@(posedge clk) reset |=> !rd_vld && !rd_fwrd)
    else stop_on_error($sformatf("Fail at %0t ns: rd_vld or rd_fwrd high after reset", $time));

  vld_after_read: assert property (@(posedge clk) disable iff (reset) read |-> ##RD_LAT rd_vld)
    else stop_on_error($sformatf("Fail at %0t ns: rd_vld low %0d cycles after read",
                                 $time, RD_LAT));

  vld_needs_read: assert property (@(posedge clk) disable iff (reset)
    rd_vld |-> $past(read, RD_LAT))
    else stop_on_error($sformatf("Fail at %0t ns: rd_vld without a read %0d cycles back",
                                 $time, RD_LAT));

  dout_match: assert property (@(posedge clk) disable iff (reset)
    rd_vld |-> rd_dout === exp_cur.data)
    else stop_on_error($sformatf("Fail at %0t ns: rd_dout %h, expected %h",
                                 $time, $sampled(rd_dout), $sampled(exp_cur.data)));

  fwrd_match: assert property (@(posedge clk) disable iff (reset)
    rd_vld |-> rd_fwrd === exp_cur.fwrd)
    else stop_on_error($sformatf("Fail at %0t ns: rd_fwrd %b, expected %b",
                                 $time, $sampled(rd_fwrd), $sampled(exp_cur.fwrd)));

  padr_match: assert property (@(posedge clk) disable iff (reset)
    rd_vld |-> rd_padr === exp_cur.padr)
    else stop_on_error($sformatf("Fail at %0t ns: rd_padr %h, expected %h",
                                 $time, $sampled(rd_padr), $sampled(exp_cur.padr)));

  initial begin
    #(WATCHDOG_NS);
    stop_on_error("Watchdog expired before the test sequence finished");
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    laddr_t a;
    laddr_t b;
    int     row;
    void'($urandom(56));
    reset  = 1'b1;
    write  = 1'b0;
    wr_adr = '0;
    bw     = '0;
    din    = '0;
    read   = 1'b0;
    rd_adr = '0;
    exp_cur = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < N_INIT; i++) begin
      run_cycle(1'b1, laddr_t'(i), '1, $urandom(), 1'b0, '0);  // No undefined words left
    end

    for (int i = 0; i < N_FULL; i++) begin
      addr_list[i] = rand_addr();
      run_cycle(1'b1, addr_list[i], '1, $urandom(), 1'b0, '0);
    end
    for (int i = 0; i < N_FULL; i++) begin
      run_cycle(1'b0, '0, '0, '0, 1'b1, addr_list[i]);
    end

    for (int i = 0; i < N_PART; i++) begin
      addr_list[i] = rand_addr();
      run_cycle(1'b1, addr_list[i], $urandom(), $urandom(), 1'b0, '0);  // Partial mask
    end
    for (int i = 0; i < N_PART; i++) begin
      run_cycle(1'b0, '0, '0, '0, 1'b1, addr_list[i]);
    end

    // One slot written, whole row read back
    for (int r = 0; r < N_ROWS; r++) begin
      row = $urandom_range(0, `MEM_NUMSROW - 1);
      a = laddr_t'(row * `MEM_NUMWRDS + $urandom_range(0, `MEM_NUMWRDS - 1));
      run_cycle(1'b1, a, $urandom(), $urandom(), 1'b0, '0);
      for (int s = 0; s < `MEM_NUMWRDS; s++) begin
        run_cycle(1'b0, '0, '0, '0, 1'b1, laddr_t'(row * `MEM_NUMWRDS + s));
      end
    end

    for (int i = 0; i < N_SAME; i++) begin
      a = rand_addr();
      run_cycle(1'b1, a, $urandom(), $urandom(), 1'b1, a);
    end
    // Same row, other slot
    for (int i = 0; i < N_SAME; i++) begin
      a = rand_addr();
      b = laddr_t'((int'(a) / `MEM_NUMWRDS) * `MEM_NUMWRDS
                   + (int'(a) % `MEM_NUMWRDS + 1 + $urandom_range(0, 2)) % `MEM_NUMWRDS);
      run_cycle(1'b1, a, $urandom(), $urandom(), 1'b1, b);
    end

    // Back-to-back reads with mixed writes
    for (int i = 0; i < N_RAND; i++) begin
      b = rand_addr();
      a = ($urandom_range(0, 3) == 0) ? b : rand_addr();
      run_cycle(1'($urandom_range(0, 1)), a, $urandom(), $urandom(), 1'b1, b);
    end

    repeat (RD_LAT + 2) idle_cycle();  // Last read is due RD_LAT cycles after its strobe

    if (exp_q.size() != 0) begin
      stop_on_error("Reads still outstanding at the end of the run");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/mem_logic_pkg.sv
design/mem_phys_pkg.sv
design/addr_split.sv
design/align_bw_1r1w.sv
design/sram_1r1w_model.sv
design/mem_subsys_top.sv
dv/mem_subsys_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := mem_subsys_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the pass message shows up in the simulation output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
